/* rv_defines.svh */
// Core widths, reset address and RV32I opcode values that RTL and testbench include
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// ======================================================================
// Widths
// ======================================================================

`define RV_XLEN       32
`define RV_NUM_REGS   32
`define RV_REG_IDX_W  5

// First fetch address out of reset
`define RV_RESET_PC   32'h0000_0000

// ======================================================================
// Major opcodes in bits [6:0] of the instruction word
// ======================================================================

`define RV_OP_REG     7'b0110011
`define RV_OP_IMM     7'b0010011
`define RV_OP_LUI     7'b0110111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_JAL     7'b1101111
`define RV_OP_STORE   7'b0100011

`endif

/* rv_pkg.sv */
// Shared package of word and index types, enums and the bundles passed between core blocks
`include "rv_defines.svh"

package rv_pkg;

   // ===================================================================
   // Plain vectors
   // ===================================================================

   // Data word, address or instruction
   typedef logic [`RV_XLEN-1:0]      word_t;
   typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

   // ===================================================================
   // Enums
   // ===================================================================

   // EQ and NE only produce the branch condition
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_EQ,
      ALU_NE
   } alu_op_e;

   typedef enum logic [1:0] {
      REQUEST,
      RESPONSE,
      HOLD
   } fetch_state_e;

   // ===================================================================
   // Bundles
   // ===================================================================

   typedef struct packed {
      alu_op_e  alu_op;
      logic     use_imm;     // Operand B from imm instead of rs2
      word_t    imm;
      reg_idx_t rs1;
      reg_idx_t rs2;
      reg_idx_t rd;
      logic     reg_write;
      logic     is_lui;
      logic     is_branch;
      logic     is_jal;
      logic     is_store;
   } ctrl_t;

   typedef struct packed {
      word_t addr;
   } imem_req_t;

   typedef struct packed {
      word_t addr;
      word_t data;
   } store_req_t;

   // Next-PC answer from execute
   typedef struct packed {
      logic  taken;
      word_t target;
   } redirect_t;

endpackage

/* rv_fetch.sv */
// Fetch unit holding the PC, the code-memory handshake and the instruction handed to execute
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_fetch (
   input  logic              clk,
   input  logic              rst_n,
   output rv_pkg::imem_req_t imem_req,
   output logic              imem_valid,
   input  logic              imem_ready,
   input  rv_pkg::word_t     imem_rdata,
   output rv_pkg::word_t     instr,
   output rv_pkg::word_t     pc,
   output logic              instr_valid,
   input  logic              instr_ready,
   input  rv_pkg::redirect_t redirect
);

   import rv_pkg::*;

   fetch_state_e state;
   fetch_state_e state_next;
   logic         imem_valid_q;
   word_t        pc_q;
   word_t        pc_next;
   word_t        instr_q;
   logic         imem_accept;
   logic         instr_accept;

   assign imem_accept  = imem_valid_q & imem_ready;
   assign instr_valid  = (state == HOLD);
   assign instr_accept = instr_valid & instr_ready;

   // Redirect is only looked at on the accepting edge
   assign pc_next = redirect.taken ? redirect.target : pc_q + word_t'(4);

   // ======================================================================
   // Fetch FSM
   // ======================================================================

   always_comb begin
      state_next = state;
      case (state)
         REQUEST: begin
            if (imem_accept) begin
               state_next = RESPONSE;
            end
         end
         // Read data is only there for one cycle
         RESPONSE: begin
            state_next = HOLD;
         end
         HOLD: begin
            if (instr_ready) begin
               state_next = REQUEST;
            end
         end
         default: begin
            state_next = REQUEST;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= REQUEST;
         imem_valid_q <= 1'b0;
         pc_q         <= `RV_RESET_PC;
         // ADDI x0, x0, 0
         instr_q      <= {25'd0, `RV_OP_IMM};
      end else begin
         state        <= state_next;
         imem_valid_q <= (state_next == REQUEST);
         if (state == RESPONSE) begin
            instr_q <= imem_rdata;
         end
         if (instr_accept) begin
            pc_q <= pc_next;
         end
      end
   end

   assign imem_req.addr = pc_q;
   assign imem_valid    = imem_valid_q;
   assign instr         = instr_q;
   assign pc            = pc_q;

   // Request address must not move while the memory stalls
   a_imem_req_stable: assert property (
      @(posedge clk) disable iff (!rst_n)
      imem_valid && !imem_ready |=> imem_valid && $stable(imem_req)
   ) else $error("imem request changed while stalled");

endmodule

/* rv_decoder.sv */
// Combinational decode of the held instruction word into the execute control bundle
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_decoder (
   input  rv_pkg::word_t instr,
   output rv_pkg::ctrl_t ctrl
);

   import rv_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   word_t      imm_u;
   word_t      imm_j;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   // ======================================================================
   // Immediates rebuilt and sign-extended from bit 31
   // ======================================================================

   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_u = {instr[31:12], 12'b0};
   assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   // ======================================================================
   // Opcode decode
   // ======================================================================

   always_comb begin
      // Default is a no-op that just steps the PC
      ctrl           = '0;
      ctrl.alu_op    = ALU_ADD;
      ctrl.imm       = imm_i;
      ctrl.rs1       = instr[19:15];
      ctrl.rs2       = instr[24:20];
      ctrl.rd        = instr[11:7];

      case (opcode)
         `RV_OP_REG: begin
            ctrl.reg_write = 1'b1;
            if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
               ctrl.alu_op = ALU_SUB;
            end else if (funct7 != 7'b0000000) begin
               ctrl.reg_write = 1'b0;
            end else begin
               case (funct3)
                  3'b000:  ctrl.alu_op = ALU_ADD;
                  3'b100:  ctrl.alu_op = ALU_XOR;
                  3'b110:  ctrl.alu_op = ALU_OR;
                  3'b111:  ctrl.alu_op = ALU_AND;
                  // Shifts and compares are not built
                  default: ctrl.reg_write = 1'b0;
               endcase
            end
         end
         `RV_OP_IMM: begin
            ctrl.use_imm   = 1'b1;
            ctrl.reg_write = (funct3 == 3'b000);
         end
         `RV_OP_LUI: begin
            ctrl.imm       = imm_u;
            ctrl.is_lui    = 1'b1;
            ctrl.reg_write = 1'b1;
         end
         `RV_OP_BRANCH: begin
            ctrl.imm = imm_b;
            if (funct3 == 3'b000) begin
               ctrl.alu_op    = ALU_EQ;
               ctrl.is_branch = 1'b1;
            end else if (funct3 == 3'b001) begin
               ctrl.alu_op    = ALU_NE;
               ctrl.is_branch = 1'b1;
            end
         end
         `RV_OP_JAL: begin
            ctrl.imm       = imm_j;
            ctrl.is_jal    = 1'b1;
            ctrl.reg_write = 1'b1;
         end
         `RV_OP_STORE: begin
            // ALU adds rs1 and imm for the address
            ctrl.imm      = imm_s;
            ctrl.use_imm  = 1'b1;
            ctrl.is_store = (funct3 == 3'b010);
         end
         default: begin
            ctrl.reg_write = 1'b0;
         end
      endcase
   end

endmodule

/* rv_regfile.sv */
// Register file with two asynchronous read ports and one write port that execute instances
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_regfile (
   input  logic             clk,
   input  logic             rst_n,
   input  rv_pkg::reg_idx_t rs1,
   input  rv_pkg::reg_idx_t rs2,
   output rv_pkg::word_t    rs1_data,
   output rv_pkg::word_t    rs2_data,
   input  rv_pkg::reg_idx_t rd,
   input  rv_pkg::word_t    rd_data,
   input  logic             rd_write
);

   import rv_pkg::*;

   word_t regs [`RV_NUM_REGS];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `RV_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (rd_write && rd != '0) begin
         regs[rd] <= rd_data;
      end
   end

   assign rs1_data = regs[rs1];
   assign rs2_data = regs[rs2];

   // x0 stays zero across all writes
   a_x0_zero: assert property (
      @(posedge clk) disable iff (!rst_n)
      (rs1 != '0 || rs1_data == '0) && (rs2 != '0 || rs2_data == '0)
   ) else $error("x0 read back non-zero");

endmodule

/* rv_execute.sv */
// Execute stage with operand select, ALU, branch decision, write-back and the store port
`timescale 1ns/1ns

module rv_execute (
   input  logic               clk,
   input  logic               rst_n,
   input  rv_pkg::ctrl_t      ctrl,
   input  rv_pkg::word_t      pc,
   input  logic               instr_valid,
   output logic               instr_ready,
   output rv_pkg::redirect_t  redirect,
   output rv_pkg::store_req_t store_req,
   output logic               store_valid,
   input  logic               store_ready
);

   import rv_pkg::*;

   word_t rs1_data;
   word_t rs2_data;
   word_t op_b;
   word_t alu_res;
   logic  alu_cond;
   word_t pc_plus4;
   word_t wb_data;
   logic  accept;

   rv_regfile i_regfile (
      .clk      (clk),
      .rst_n    (rst_n),
      .rs1      (ctrl.rs1),
      .rs2      (ctrl.rs2),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .rd       (ctrl.rd),
      .rd_data  (wb_data),
      .rd_write (ctrl.reg_write & accept)
   );

   // ======================================================================
   // ALU
   // ======================================================================

   assign op_b = ctrl.use_imm ? ctrl.imm : rs2_data;

   always_comb begin
      alu_res  = '0;
      alu_cond = 1'b0;
      case (ctrl.alu_op)
         ALU_ADD: alu_res  = rs1_data + op_b;
         ALU_SUB: alu_res  = rs1_data - op_b;
         ALU_AND: alu_res  = rs1_data & op_b;
         ALU_OR:  alu_res  = rs1_data | op_b;
         ALU_XOR: alu_res  = rs1_data ^ op_b;
         ALU_EQ:  alu_cond = (rs1_data == op_b);
         ALU_NE:  alu_cond = (rs1_data != op_b);
         default: alu_res  = '0;
      endcase
   end

   // ======================================================================
   // Write-back and next PC
   // ======================================================================

   assign pc_plus4 = pc + word_t'(4);

   always_comb begin
      if (ctrl.is_jal) begin
         wb_data = pc_plus4;
      end else if (ctrl.is_lui) begin
         wb_data = ctrl.imm;
      end else begin
         wb_data = alu_res;
      end
   end

   assign redirect.taken  = ctrl.is_jal | (ctrl.is_branch & alu_cond);
   assign redirect.target = pc + ctrl.imm;

   // Only a stalled store holds the instruction back
   assign instr_ready = ~ctrl.is_store | store_ready;
   assign accept      = instr_valid & instr_ready;

   // Store address comes out of the ALU adder
   assign store_valid    = instr_valid & ctrl.is_store;
   assign store_req.addr = alu_res;
   assign store_req.data = rs2_data;

   // Payload held by fetch keeping the instruction in HOLD
   a_store_req_stable: assert property (
      @(posedge clk) disable iff (!rst_n)
      store_valid && !store_ready |=> store_valid && $stable(store_req)
   ) else $error("store request changed while stalled");

endmodule

/* rv_core.sv */
// Core top level that ties fetch, decode and execute to the code and data memory ports
`timescale 1ns/1ns

module rv_core (
   input  logic               clk,
   input  logic               rst_n,
   // Code memory
   output rv_pkg::imem_req_t  imem_req,
   output logic               imem_valid,
   input  logic               imem_ready,
   input  rv_pkg::word_t      imem_rdata,
   // Data memory, write only
   output rv_pkg::store_req_t store_req,
   output logic               store_valid,
   input  logic               store_ready
);

   import rv_pkg::*;

   word_t     instr;
   word_t     pc;
   logic      instr_valid;
   logic      instr_ready;
   ctrl_t     ctrl;
   redirect_t redirect;

   rv_fetch i_fetch (
      .clk         (clk),
      .rst_n       (rst_n),
      .imem_req    (imem_req),
      .imem_valid  (imem_valid),
      .imem_ready  (imem_ready),
      .imem_rdata  (imem_rdata),
      .instr       (instr),
      .pc          (pc),
      .instr_valid (instr_valid),
      .instr_ready (instr_ready),
      .redirect    (redirect)
   );

   rv_decoder i_decoder (
      .instr (instr),
      .ctrl  (ctrl)
   );

   rv_execute i_execute (
      .clk         (clk),
      .rst_n       (rst_n),
      .ctrl        (ctrl),
      .pc          (pc),
      .instr_valid (instr_valid),
      .instr_ready (instr_ready),
      .redirect    (redirect),
      .store_req   (store_req),
      .store_valid (store_valid),
      .store_ready (store_ready)
   );

endmodule

/* tb_rv_core.sv */
// Testbench that runs a program image on the core and checks its stores against a reference model
`timescale 1ns/1ns
`include "rv_defines.svh"

module tb_rv_core;

   import rv_pkg::*;

   localparam int MEM_WORDS    = 64;
   localparam int DRAIN_CYCLES = 5000;
   localparam int QUIET_CYCLES = 300;

   logic        clk;
   logic        rst_n;
   imem_req_t   imem_req;
   logic        imem_valid;
   logic        imem_ready;
   word_t       imem_rdata;
   store_req_t  store_req;
   logic        store_valid;
   logic        store_ready;

   word_t       code_mem [MEM_WORDS];
   word_t       exp_addr [$];
   word_t       exp_data [$];
   logic [15:0] lfsr;
   logic        fetch_seen;
   logic        store_held;
   store_req_t  held_req;

   rv_core i_dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .imem_req    (imem_req),
      .imem_valid  (imem_valid),
      .imem_ready  (imem_ready),
      .imem_rdata  (imem_rdata),
      .store_req   (store_req),
      .store_valid (store_valid),
      .store_ready (store_ready)
   );

   always #20 clk = ~clk;

   // ======================================================================
   // Random source and instruction encoders
   // ======================================================================

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic rand_bit();
      lfsr = lfsr_step(lfsr);
      return lfsr[0];
   endfunction

   function automatic word_t rand_bits(input int n);
      word_t v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], rand_bit()};
      end
      return v;
   endfunction

   function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd);
      return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
   endfunction

   function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1, input reg_idx_t rd);
      return {imm, rs1, 3'b000, rd, `RV_OP_IMM};
   endfunction

   function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2, input reg_idx_t rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
   endfunction

   function automatic word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
   endfunction

   function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
   endfunction

   // ======================================================================
   // Program image and reference interpreter
   // ======================================================================

   function automatic void load_program();
      word_t imm_a;
      word_t imm_u;
      for (int i = 0; i < MEM_WORDS; i++) begin
         // Custom-0 opcode, a no-op tagged with its own index
         code_mem[i] = {i[24:0], 7'b0001011};
      end
      imm_a = rand_bits(12);
      // Low bit forced so x2 is never zero
      imm_u = rand_bits(20) | word_t'(1);
      code_mem[0] = enc_i(imm_a[11:0], 5'd0, 5'd1);
      code_mem[1] = {imm_u[19:0], 5'd2, `RV_OP_LUI};
      code_mem[2] = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
      code_mem[3] = enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd4);
      code_mem[4] = enc_r(7'h00, 5'd4, 5'd3, 3'b111, 5'd5);
      code_mem[5] = enc_r(7'h00, 5'd4, 5'd3, 3'b110, 5'd6);
      code_mem[6] = enc_r(7'h00, 5'd4, 5'd3, 3'b100, 5'd7);
      for (int r = 1; r < 8; r++) begin
         code_mem[6 + r] = enc_s(12'h100 + 12'(4 * r), 5'(r), 5'd0);
      end
      // Skipped stores all go to 0x1F0
      code_mem[14] = enc_b(13'd8, 5'd1, 5'd1, 3'b000);
      code_mem[15] = enc_s(12'h1f0, 5'd1, 5'd0);
      code_mem[16] = enc_b(13'd8, 5'd2, 5'd0, 3'b001);
      code_mem[17] = enc_s(12'h1f0, 5'd2, 5'd0);
      code_mem[18] = enc_b(13'd8, 5'd2, 5'd1, 3'b000);
      code_mem[19] = enc_s(12'h120, 5'd3, 5'd0);
      code_mem[20] = enc_j(21'd8, 5'd8);
      code_mem[21] = enc_s(12'h1f0, 5'd1, 5'd0);
      code_mem[22] = enc_s(12'h124, 5'd8, 5'd0);
      code_mem[23] = enc_i(12'h005, 5'd0, 5'd0);
      code_mem[24] = enc_s(12'h128, 5'd0, 5'd0);
      code_mem[25] = enc_j(21'd0, 5'd0);
   endfunction

   function automatic void run_reference();
      word_t    regs [`RV_NUM_REGS];
      word_t    pc;
      word_t    pc_next;
      word_t    ins;
      word_t    a;
      word_t    b;
      reg_idx_t rd;
      logic     done;
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
         regs[i] = '0;
      end
      pc   = `RV_RESET_PC;
      done = 1'b0;
      for (int step = 0; step < 500 && !done; step++) begin
         ins     = code_mem[pc[7:2]];
         a       = regs[ins[19:15]];
         b       = regs[ins[24:20]];
         rd      = ins[11:7];
         pc_next = pc + word_t'(4);
         case (ins[6:0])
            `RV_OP_REG: begin
               case ({ins[30], ins[14:12]})
                  4'b0000: regs[rd] = a + b;
                  4'b1000: regs[rd] = a - b;
                  4'b0111: regs[rd] = a & b;
                  4'b0110: regs[rd] = a | b;
                  4'b0100: regs[rd] = a ^ b;
                  default: ;
               endcase
            end
            `RV_OP_IMM: regs[rd] = a + {{20{ins[31]}}, ins[31:20]};
            `RV_OP_LUI: regs[rd] = {ins[31:12], 12'h000};
            `RV_OP_STORE: begin
               exp_addr.push_back(a + {{20{ins[31]}}, ins[31:25], ins[11:7]});
               exp_data.push_back(b);
            end
            `RV_OP_BRANCH: begin
               // funct3 bit 0 picks NE over EQ
               if ((a == b) != ins[12]) begin
                  pc_next = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
               end
            end
            `RV_OP_JAL: begin
               pc_next  = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
               regs[rd] = pc + word_t'(4);
               done     = (pc_next == pc);
            end
            default: ;
         endcase
         regs[0] = '0;
         pc      = pc_next;
      end
   endfunction

   // ======================================================================
   // Checks
   // ======================================================================

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic check_addr(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         report_failure($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
      end
   endtask

   task automatic check_data(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         report_failure($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
      end
   endtask

   // Code memory with random ready and data valid for one cycle after accept
   always @(posedge clk) begin
      if (!rst_n) begin
         imem_ready  <= 1'b0;
         store_ready <= 1'b0;
         imem_rdata  <= '0;
      end else begin
         imem_ready  <= rand_bit();
         store_ready <= rand_bit();
         imem_rdata  <= '0;
         if (imem_valid && imem_ready) begin
            if (imem_req.addr[31:8] != '0 || imem_req.addr[1:0] != '0) begin
               report_failure("code fetch outside the program image");
            end
            if (!fetch_seen) begin
               check_addr("imem_req.addr", imem_req.addr, `RV_RESET_PC);
            end
            fetch_seen <= 1'b1;
            imem_rdata <= code_mem[imem_req.addr[7:2]];
         end
      end
   end

   // Store comparison and stall stability
   always @(posedge clk) begin
      if (rst_n) begin
         if (store_held) begin
            if (!store_valid) begin
               report_failure("store request dropped before it was accepted");
            end
            check_addr("store_req.addr", store_req.addr, held_req.addr);
            check_data("store_req.data", store_req.data, held_req.data);
         end
         if (store_valid && store_ready) begin
            if (exp_addr.size() == 0) begin
               report_failure("store seen beyond the expected sequence");
            end else begin
               check_addr("store_req.addr", store_req.addr, exp_addr.pop_front());
               check_data("store_req.data", store_req.data, exp_data.pop_front());
            end
         end
         store_held <= store_valid && !store_ready;
         held_req   <= store_req;
      end
   end

   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      imem_ready  = 1'b0;
      imem_rdata  = '0;
      store_ready = 1'b0;
      lfsr        = 16'd58;
      fetch_seen  = 1'b0;
      store_held  = 1'b0;
      held_req    = '0;
      load_program();
      run_reference();
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      for (int c = 0; c < DRAIN_CYCLES && exp_addr.size() != 0; c++) begin
         @(posedge clk);
      end
      if (exp_addr.size() != 0) begin
         report_failure("timeout waiting for the expected stores");
      end else begin
         // Any store in the self-loop window is flagged by the checker
         for (int c = 0; c < QUIET_CYCLES; c++) begin
            @(posedge clk);
         end
         $display("Simulation finished: PASS");
         $finish;
      end
   end

endmodule

/* vlog.f */
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_decoder.sv
rv_regfile.sv
rv_execute.sv
rv_core.sv
tb_rv_core.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_rv_core
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
